// File: sim/pcx_stim.txt
// Columns: source core, destination bank, atomic flag, data word (hex)
// A row with source f ends a phase: random traffic, bank 1 stall, bank 0 round robin
0 0 0 a0000001
1 1 0 b1000001
2 0 1 c2000001
2 0 0 c2000002
0 1 0 a0000002
1 0 1 b1000002
1 0 0 b1000003
0 0 0 a0000003
2 1 0 c2000003
0 1 1 a0000004
0 1 0 a0000005
1 1 0 b1000004
2 0 0 c2000004
f 0 0 00000000
2 1 0 d2000001
2 1 0 d2000002
2 1 0 d2000003
2 1 0 d2000004
2 1 0 d2000005
f 0 0 00000000
0 0 0 e0000001
1 0 0 e1000001
2 0 0 e2000001
0 0 0 e0000002
1 0 0 e1000002
2 0 0 e2000002
0 0 0 e0000003
1 0 0 e1000003
2 0 0 e2000003
f 0 0 00000000

// File: pcx_xbar.f
+incdir+src
src/pcx_pkg.sv
src/pcx_arb_if.sv
src/pcx_queue.sv
src/pcx_arb.sv
src/pcx_dp_mux.sv
src/pcx_xbar.sv
sim/pcx_xbar_tb.sv

// File: Bender.yml
package:
  name: pcx_xbar

sources:
  - include_dirs:
      - src
    files:
      - src/pcx_pkg.sv
      - src/pcx_arb_if.sv
      - src/pcx_queue.sv
      - src/pcx_arb.sv
      - src/pcx_dp_mux.sv
      - src/pcx_xbar.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/pcx_xbar_tb.sv

// File: sim/pcx_xbar_tb.sv
`include "pcx_defines.svh"

module pcx_xbar_tb import pcx_pkg::*; ();

   localparam int n_src    = `PCX_N_SRC;
   localparam int n_dst    = `PCX_N_DST;
   localparam int n_words  = 256;
   localparam int wait_max = 400;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic [n_src-1:0]       src_valid;
   logic [n_src-1:0]       src_ready;
   pcx_dst_t               src_dest [n_src];
   logic [n_src-1:0]       src_atom;
   logic [`PCX_DATA_W-1:0] src_data [n_src];
   logic [n_dst-1:0]       dst_valid;
   logic [n_dst-1:0]       dst_ready;
   pcx_src_t               dst_src [n_dst];
   logic [n_dst-1:0]       dst_atom;
   logic [`PCX_DATA_W-1:0] dst_data [n_dst];

   // Rows per phase and core, expected packets and accept edges per core and bank
   logic [31:0]            stim_mem [n_words];
   pcx_pkt_t               pkt_q [3*n_src][$];
   logic [`PCX_DATA_W:0]   exp_q [n_src*n_dst][$];
   int                     acc_q [n_src*n_dst][$];

   logic [31:0]            lfsr = 32'h74f3_4c54;
   logic [n_src-1:0]       src_gap;
   logic [n_dst-1:0]       ready_rnd;
   logic [n_dst-1:0]       ready_hold;
   logic                   use_gaps;
   logic                   rand_ready;
   logic                   rr_check;
   logic                   rr_seen;
   pcx_src_t               rr_prev;
   logic [n_dst-1:0]       pair_open;
   pcx_src_t               pair_src [n_dst];
   int                     cyc = 0;
   int                     acc_cnt = 0;
   int                     deliv_cnt = 0;
   int                     err_cnt = 0;
   int                     fail_cnt = 0;

   pcx_xbar pcx_xbar_i (.*);

   always #4 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   //////////////////////////////////////////////////
   // Random source, taps 32 22 2 1
   //////////////////////////////////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] draw_bits(input int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[6:0], lfsr[31]};
         lfsr = lfsr_next(lfsr);
      end
      return r;
   endfunction

   // New choices at the falling edge, used at the next rising edge
   always @(negedge clk) begin : random_gen
      for (int s = 0; s < n_src; s++) src_gap[s] = (draw_bits(2) == 8'd0);
      for (int b = 0; b < n_dst; b++) ready_rnd[b] = (draw_bits(2) != 8'd0);
   end

   always @(posedge clk) begin : ready_drive
      if (rand_ready) dst_ready <= ready_rnd;
      else dst_ready <= ready_hold;
   end

   task automatic check_val(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      if (expected !== actual) begin
         $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
         err_cnt++;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic load_stim();
      int       ph;
      int       s;
      pcx_pkt_t p;
      ph = 0;
      for (int i = 0; i < n_words; i++) stim_mem[i] = 32'hfeed_0000 + 32'(i);
      $readmemh("sim/pcx_stim.txt", stim_mem);
      for (int i = 0; i + 3 < n_words && ph < 3; i += 4) begin
         s = int'(stim_mem[i]);
         if (s == 'hf) begin
            ph++;
         end else if (s < n_src) begin
            p.dst  = stim_mem[i+1][0];
            p.atom = stim_mem[i+2][0];
            p.data = stim_mem[i+3];
            pkt_q[ph*n_src + s].push_back(p);
            exp_q[s*n_dst + int'(p.dst)].push_back({p.atom, p.data});
         end else begin
            $display("Stimulus row %0d names core %0d, which does not exist", i / 4, s);
            fail_cnt++;
         end
      end
      if (ph < 3) begin
         $display("Stimulus file ends before the third phase marker");
         fail_cnt++;
      end
   endtask

   // Presents one core's rows of a phase in order, valid held until accepted
   task automatic drive_core(input int s, input int ph);
      pcx_pkt_t p;
      int       t;
      int       gap;
      @(posedge clk);
      while (pkt_q[ph*n_src + s].size() > 0) begin
         p   = pkt_q[ph*n_src + s].pop_front();
         gap = 0;
         while (use_gaps && src_gap[s] && gap < 3) begin
            src_valid[s] <= 1'b0;
            @(posedge clk);
            gap++;
         end
         src_valid[s] <= 1'b1;
         src_dest[s]  <= p.dst;
         src_atom[s]  <= p.atom;
         src_data[s]  <= p.data;
         t = 0;
         do begin
            @(negedge clk);
            t++;
         end while (!src_ready[s] && t < wait_max);
         if (!src_ready[s]) begin
            $display("Core %0d timed out waiting for src_ready", s);
            fail_cnt++;
         end
         @(posedge clk);
      end
      src_valid[s] <= 1'b0;
   endtask

   task automatic drain(input string what);
      int t;
      t = 0;
      while (deliv_cnt != acc_cnt && t < wait_max) begin
         @(posedge clk);
         t++;
      end
      if (deliv_cnt != acc_cnt) begin
         $display("Timed out in %s with %0d of %0d packets delivered", what, deliv_cnt, acc_cnt);
         fail_cnt++;
      end
   endtask

   //////////////////////////////////////////////////
   // Monitor and scoreboard
   //////////////////////////////////////////////////

   // Inputs move only on rising edges, so the falling edge sees the next transfer
   always @(negedge clk) begin : monitor
      int                   idx;
      int                   acc_edge;
      logic [`PCX_DATA_W:0] e;
      if (rst_n) begin
         for (int b = 0; b < n_dst; b++) begin
            if (dst_valid[b] && dst_ready[b]) begin
               idx = int'(dst_src[b]) * n_dst + b;
               deliv_cnt++;
               if (int'(dst_src[b]) >= n_src || exp_q[idx].size() == 0) begin
                  $display("Bank %0d delivered an unexpected packet from core %0d at %0t",
                           b, dst_src[b], $time);
                  fail_cnt++;
               end else begin
                  e = exp_q[idx].pop_front();
                  check_val("dst_atom", e[`PCX_DATA_W], dst_atom[b]);
                  check_val("dst_data", e[`PCX_DATA_W-1:0], dst_data[b]);
                  acc_edge = (acc_q[idx].size() > 0) ? acc_q[idx].pop_front() : cyc + 1;
                  if (cyc + 1 - acc_edge < 2) begin
                     $display("Bank %0d got a packet from core %0d too soon after accept",
                              b, dst_src[b]);
                     fail_cnt++;
                  end
               end
               // Follower of an atomic packet
               if (pair_open[b]) check_val("dst_src", pair_src[b], dst_src[b]);
               pair_open[b] = dst_atom[b];
               pair_src[b]  = dst_src[b];
               if (b == 0 && rr_check) begin
                  if (rr_seen) check_val("dst_src", (int'(rr_prev) + 1) % n_src, dst_src[b]);
                  rr_seen = 1'b1;
                  rr_prev = dst_src[b];
               end
            end
         end
         for (int s = 0; s < n_src; s++) begin
            if (src_valid[s] && src_ready[s]) begin
               acc_q[s*n_dst + int'(src_dest[s])].push_back(cyc + 1);
               acc_cnt++;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////

   initial begin : main
      rst_n      = 1'b0;
      src_valid  = '0;
      src_atom   = '0;
      dst_ready  = '0;
      ready_hold = '0;
      rand_ready = 1'b0;
      use_gaps   = 1'b0;
      rr_check   = 1'b0;
      rr_seen    = 1'b0;
      rr_prev    = '0;
      pair_open  = '0;
      for (int s = 0; s < n_src; s++) begin
         src_dest[s] = '0;
         src_data[s] = '0;
      end
      for (int b = 0; b < n_dst; b++) pair_src[b] = '0;
      load_stim();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Idle after reset
      @(negedge clk);
      check_val("dst_valid", '0, dst_valid);
      check_val("src_ready", {n_src{1'b1}}, src_ready);

      // Random gaps on the cores, random stalls on both banks
      use_gaps   = 1'b1;
      rand_ready = 1'b1;
      fork
         drive_core(0, 0);
         drive_core(1, 0);
         drive_core(2, 0);
      join
      drain("random traffic");

      // Bank 1 stalled until core 2 backs up
      @(negedge clk);
      use_gaps      = 1'b0;
      rand_ready    = 1'b0;
      ready_hold    = '1;
      ready_hold[1] = 1'b0;
      fork
         drive_core(2, 1);
         begin : stall_bank1
            int t;
            t = 0;
            while (src_ready[2] && t < wait_max) begin
               @(negedge clk);
               t++;
            end
            if (src_ready[2]) begin
               $display("src_ready of core 2 never dropped while bank 1 was stalled");
               fail_cnt++;
            end
            repeat (4) @(negedge clk);
            ready_hold = '1;
         end
      join
      drain("bank 1 stall");

      // All cores to bank 0 without gaps
      @(posedge clk);
      rr_seen  = 1'b0;
      rr_check = 1'b1;
      @(negedge clk);
      fork
         drive_core(0, 2);
         drive_core(1, 2);
         drive_core(2, 2);
      join
      drain("round robin");
      rr_check = 1'b0;

      for (int i = 0; i < n_src*n_dst; i++) begin
         if (exp_q[i].size() != 0) begin
            $display("%0d packets from core %0d to bank %0d never arrived",
                     exp_q[i].size(), i / n_dst, i % n_dst);
            fail_cnt++;
         end
      end
      $display("Errors: %0d wrong values, %0d other failures", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: src/pcx_xbar.sv
`include "pcx_defines.svh"

module pcx_xbar import pcx_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,

   // Core side
   input  logic [`PCX_N_SRC-1:0]  src_valid,
   output logic [`PCX_N_SRC-1:0]  src_ready,
   input  pcx_dst_t               src_dest [`PCX_N_SRC],
   input  logic [`PCX_N_SRC-1:0]  src_atom,
   input  logic [`PCX_DATA_W-1:0] src_data [`PCX_N_SRC],

   // Bank side
   output logic [`PCX_N_DST-1:0]  dst_valid,
   input  logic [`PCX_N_DST-1:0]  dst_ready,
   output pcx_src_t               dst_src [`PCX_N_DST],
   output logic [`PCX_N_DST-1:0]  dst_atom,
   output logic [`PCX_DATA_W-1:0] dst_data [`PCX_N_DST]
);

   logic [`PCX_N_SRC-1:0] core_full;
   logic [`PCX_N_SRC-1:0] core_head_valid;
   logic [`PCX_N_SRC-1:0] core_pop;
   pcx_pkt_t              core_in [`PCX_N_SRC];
   pcx_pkt_t              core_head [`PCX_N_SRC];

   logic [`PCX_N_DST-1:0] bank_full;
   logic [`PCX_N_DST-1:0] bank_push;
   logic [`PCX_N_DST-1:0] bank_pop;
   pcx_out_t              bank_in [`PCX_N_DST];
   pcx_out_t              bank_head [`PCX_N_DST];

   pcx_arb_if arb_if [`PCX_N_DST] ();

   //////////////////////////////////////////////////
   // Core queues
   //////////////////////////////////////////////////

   for (genvar s = 0; s < `PCX_N_SRC; s++) begin : g_core
      assign core_in[s]   = '{dst: src_dest[s], atom: src_atom[s], data: src_data[s]};
      assign src_ready[s] = !core_full[s];

      pcx_queue #(.payload_t(pcx_pkt_t)) core_q (
         .clk        (clk),
         .rst_n      (rst_n),
         .push       (src_valid[s]),
         .push_data  (core_in[s]),
         .full       (core_full[s]),
         .pop        (core_pop[s]),
         .head_valid (core_head_valid[s]),
         .head       (core_head[s])
      );
   end

   //////////////////////////////////////////////////
   // Bank arbiters and output queues
   //////////////////////////////////////////////////

   for (genvar b = 0; b < `PCX_N_DST; b++) begin : g_bank
      pcx_arb bank_arb (
         .clk   (clk),
         .rst_n (rst_n),
         .arb   (arb_if[b])
      );

      assign bank_pop[b] = dst_valid[b] && dst_ready[b];

      pcx_queue #(.payload_t(pcx_out_t)) bank_q (
         .clk        (clk),
         .rst_n      (rst_n),
         .push       (bank_push[b]),
         .push_data  (bank_in[b]),
         .full       (bank_full[b]),
         .pop        (bank_pop[b]),
         .head_valid (dst_valid[b]),
         .head       (bank_head[b])
      );

      assign dst_src[b]  = bank_head[b].src;
      assign dst_atom[b] = bank_head[b].atom;
      assign dst_data[b] = bank_head[b].data;
   end

   pcx_dp_mux dp (
      .head_valid (core_head_valid),
      .head       (core_head),
      .pop        (core_pop),
      .full       (bank_full),
      .push       (bank_push),
      .push_data  (bank_in),
      .arb        (arb_if)
   );

endmodule

// File: src/pcx_dp_mux.sv
`include "pcx_defines.svh"

module pcx_dp_mux import pcx_pkg::*; (
   // Core queue heads
   input  logic [`PCX_N_SRC-1:0] head_valid,
   input  pcx_pkt_t              head [`PCX_N_SRC],
   output logic [`PCX_N_SRC-1:0] pop,

   // Bank queue inputs
   input  logic [`PCX_N_DST-1:0] full,
   output logic [`PCX_N_DST-1:0] push,
   output pcx_out_t              push_data [`PCX_N_DST],

   // One arbiter per bank
   pcx_arb_if.datapath           arb [`PCX_N_DST]
);

   // Grants of every bank, indexed [bank][core]
   logic [`PCX_N_SRC-1:0] grant [`PCX_N_DST];

   //////////////////////////////////////////////////
   // Per bank request decode and packet select
   //////////////////////////////////////////////////

   for (genvar b = 0; b < `PCX_N_DST; b++) begin : g_bank

      // A head requests only the bank it addresses
      for (genvar s = 0; s < `PCX_N_SRC; s++) begin : g_src
         assign arb[b].req[s]  = head_valid[s] && (head[s].dst == pcx_dst_t'(b));
         assign arb[b].atom[s] = head[s].atom;
      end

      assign arb[b].room = !full[b];
      assign grant[b]    = arb[b].grant;
      assign push[b]     = |grant[b];

      // One-hot select, tag with source index
      always_comb begin
         push_data[b] = '0;
         for (int s = 0; s < `PCX_N_SRC; s++) begin
            if (grant[b][s]) begin
               push_data[b].src  = pcx_src_t'(s);
               push_data[b].atom = head[s].atom;
               push_data[b].data = head[s].data;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Core pops
   //////////////////////////////////////////////////

   // A head targets a single bank, so at most one grant per core
   always_comb begin
      pop = '0;
      for (int b = 0; b < `PCX_N_DST; b++) begin
         pop = pop | grant[b];
      end
   end

endmodule

// File: src/pcx_arb.sv
`include "pcx_defines.svh"

module pcx_arb import pcx_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   pcx_arb_if.arbiter  arb
);

   //////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////

   // First core to be considered in the next round
   pcx_src_t ptr;

   // Atomic pair in flight, bank reserved for lock_src
   logic     lock_valid;
   pcx_src_t lock_src;

   pcx_src_t win_idx;
   logic     win_found;
   logic     take;

   //////////////////////////////////////////////////
   // Winner selection
   //////////////////////////////////////////////////

   always_comb begin
      int idx;
      win_found = 1'b0;
      win_idx   = '0;
      // Rotating scan starting at ptr
      for (int i = 0; i < `PCX_N_SRC; i++) begin
         idx = (int'(ptr) + i) % `PCX_N_SRC;
         if (!win_found && arb.req[idx]) begin
            win_found = 1'b1;
            win_idx   = pcx_src_t'(idx);
         end
      end
      // Only the locked core may win while a pair is open
      if (lock_valid) begin
         win_found = arb.req[lock_src];
         win_idx   = lock_src;
      end
   end

   // No grant without room in the bank queue
   assign take = win_found && arb.room;

   always_comb begin
      for (int s = 0; s < `PCX_N_SRC; s++) begin
         arb.grant[s] = take && (win_idx == pcx_src_t'(s));
      end
   end

   //////////////////////////////////////////////////
   // Pointer and lock update
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr        <= '0;
         lock_valid <= 1'b0;
         lock_src   <= '0;
      end else if (take) begin
         ptr <= (win_idx == pcx_src_t'(`PCX_N_SRC - 1)) ? '0 : pcx_src_t'(win_idx + 1'b1);
         // An atomic grant opens the lock, the follower closes it again
         lock_valid <= arb.atom[win_idx];
         lock_src   <= win_idx;
      end
   end

endmodule

// File: src/pcx_queue.sv
`include "pcx_defines.svh"

module pcx_queue import pcx_pkg::*; #(
   parameter type         payload_t = pcx_pkt_t,
   parameter int unsigned depth     = `PCX_QUEUE_DEPTH
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   output logic     full,
   input  logic     pop,
   output logic     head_valid,
   output payload_t head
);

   localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int unsigned cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Circular pointer advance, depth need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full       = (count == cnt_w'(depth));
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];

   // Push when full is dropped, pop on empty is ignored
   assign do_push = push && !full;
   assign do_pop  = pop && head_valid;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: src/pcx_arb_if.sv
`include "pcx_defines.svh"

// Request and grant lines between the datapath and one bank arbiter
interface pcx_arb_if;

   // One bit per core
   logic [`PCX_N_SRC-1:0] req;
   logic [`PCX_N_SRC-1:0] atom;

   // Bank output queue can take a packet this cycle
   logic                  room;

   // One-hot, at most one core per cycle
   logic [`PCX_N_SRC-1:0] grant;

   modport datapath (output req, output atom, output room, input grant);

   modport arbiter (input req, input atom, input room, output grant);

endinterface

// File: src/pcx_pkg.sv
`include "pcx_defines.svh"

package pcx_pkg;

   // Core index, wide enough for PCX_N_SRC cores
   typedef logic [1:0] pcx_src_t;

   // Cache bank index
   typedef logic pcx_dst_t;

   // Packet as submitted by a core
   typedef struct packed {
      pcx_dst_t                dst;
      logic                    atom;
      logic [`PCX_DATA_W-1:0]  data;
   } pcx_pkt_t;

   // Packet as delivered to a bank, tagged with its source core
   typedef struct packed {
      pcx_src_t                src;
      logic                    atom;
      logic [`PCX_DATA_W-1:0]  data;
   } pcx_out_t;

endpackage

// File: src/pcx_defines.svh
`ifndef PCX_DEFINES_SVH
`define PCX_DEFINES_SVH

// Number of cores driving the crossbar
`define PCX_N_SRC 3

// Number of cache banks on the far side
`define PCX_N_DST 2

// Packet payload word
`define PCX_DATA_W 32

// Entries per queue, core side and bank side alike
`define PCX_QUEUE_DEPTH 2

`endif
